// File: verification/vic_fetch_golden.txt
// den _ yscroll _ sprite_dma _ base _ sprite_ptr at line end (sprite 0 first)
// then colour and pixel_on of the first pixel of columns 0, 3 and 39; one line per raster line
1_0_ff_070_ff727476787a7c7e_01_01_01
1_1_a5_000_00ff04ffff0aff0e_60_60_60
1_2_00_36c_ffffffffffffffff_60_60_01
1_3_ff_f70_70727476787a7c7e_01_01_01
1_4_a5_070_70ff74ffff7aff7e_01_01_01
1_5_00_000_ffffffffffffffff_60_60_60
1_6_ff_36c_6c6e70727476787a_60_60_01
1_7_a5_f70_70ff74ffff7aff7e_01_01_01
1_0_00_070_ffffffffffffffff_01_01_01
1_1_ff_000_00020406080a0c0e_60_60_60
1_2_a5_36c_6cff70ffff76ff7a_60_60_01
1_3_00_f70_ffffffffffffffff_01_01_01
1_4_ff_070_70727476787a7c7e_01_01_01
1_5_a5_000_00ff04ffff0aff0e_60_60_60
1_6_00_36c_ffffffffffffffff_60_60_01
1_7_ff_f70_70727476787a7c7e_01_01_01
1_0_a5_070_70ff74ffff7aff7e_01_01_01
1_1_00_000_ffffffffffffffff_60_60_60
1_2_ff_36c_6c6e70727476787a_60_60_01
1_3_a5_f70_70ff74ffff7aff7e_01_01_01
1_4_00_070_ffffffffffffffff_01_01_01
1_5_ff_000_00020406080a0c0e_60_60_60
1_6_a5_36c_6cff70ffff76ff7a_60_60_01
1_7_00_f70_ffffffffffffffff_01_01_01
1_0_ff_070_70727476787a7c7e_01_01_01
1_1_a5_000_00ff04ffff0aff0e_60_60_60
1_2_00_36c_ffffffffffffffff_60_60_01
1_3_ff_f70_70727476787a7c7e_01_01_01
1_4_a5_070_70ff74ffff7aff7e_01_01_01
1_5_00_000_ffffffffffffffff_60_60_60
1_6_ff_36c_6c6e70727476787a_60_60_01
1_7_a5_f70_70ff74ffff7aff7e_01_01_01
1_0_00_070_ffffffffffffffff_01_01_01
1_1_ff_000_00020406080a0c0e_60_60_60
1_2_a5_36c_6cff70ffff76ff7a_60_60_01
1_3_00_f70_ffffffffffffffff_01_01_01
1_4_ff_070_70727476787a7c7e_01_01_01
1_5_a5_000_00ff04ffff0aff0e_60_60_60
1_6_00_36c_ffffffffffffffff_60_60_01
1_7_ff_f70_70727476787a7c7e_01_01_01
1_0_a5_070_70ff74ffff7aff7e_01_01_01
1_1_00_000_ffffffffffffffff_60_60_60
1_2_ff_36c_6c6e70727476787a_60_60_01
1_3_a5_f70_70ff74ffff7aff7e_01_01_01
1_4_00_070_ffffffffffffffff_01_01_01
1_5_ff_000_00020406080a0c0e_60_60_60
1_6_a5_36c_6cff70ffff76ff7a_60_60_01
1_7_00_f70_ffffffffffffffff_01_01_01
// lines 48 to 55 with den low
0_0_ff_070_70727476787a7c7e_01_01_01
0_1_a5_000_00ff04ffff0aff0e_60_60_60
0_2_00_36c_ffffffffffffffff_60_60_01
0_3_ff_f70_70727476787a7c7e_01_01_01
0_4_a5_070_70ff74ffff7aff7e_01_01_01
0_5_00_000_ffffffffffffffff_60_60_60
0_6_ff_36c_6c6e70727476787a_60_60_01
0_7_a5_f70_70ff74ffff7aff7e_01_01_01
// line 56 is a bad line, 57 to 59 replay its colours
1_0_ff_3a0_a1a3a5a7a9abadaf_31_31_31
1_0_a5_070_70ff74ffff7aff7e_31_31_31
1_0_00_000_ffffffffffffffff_60_60_60
1_0_ff_36c_6c6e70727476787a_60_60_31

// File: flist.f
hdl/vic_bus_pkg.sv
hdl/vic_timing_pkg.sv
hdl/cycle_sequencer.sv
hdl/bus_access.sv
hdl/pixel_sequencer.sv
hdl/vic_fetch_top.sv
verification/tb_vic_fetch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_vic_fetch
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.DEFAULT_GOAL := help

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_vic_fetch.sv
`timescale 1ns/100ps

module tb_vic_fetch;
    import vic_bus_pkg::*;
    import vic_timing_pkg::*;

    localparam int NUM_LINES = 60;
    localparam string GOLDEN_FILE = "verification/vic_fetch_golden.txt";
    localparam logic [3:0] BG_COLOR = 4'h6;
    // strobe is sampled at the end of clock 0, first pixel is out from clock 3 to 6
    localparam int FIRST_PIXEL_CLOCK = 3;
    localparam int TIMEOUT_CYCLES = NUM_LINES * CYCLES_PER_LINE * DOT4X_PER_PHI + 4040;

    // one record per raster line, fields in file order
    typedef struct packed {
        logic [3:0]  den;
        logic [3:0]  yscroll;
        logic [7:0]  sprite_dma;
        logic [11:0] base;
        logic [63:0] sprite_ptr;
        // colour nibble then pixel_on nibble
        logic [7:0]  col0;
        logic [7:0]  col3;
        logic [7:0]  col39;
    } golden_rec_t;

    logic                       clk_dot4x;
    logic                       rst;
    logic                       den;
    logic [2:0]                 yscroll;
    logic [3:0]                 bg_color;
    logic [NUM_SPRITES-1:0]     sprite_dma;
    logic [11:0]                dbi;
    logic [5:0]                 raster_x;
    logic [8:0]                 raster_y;
    logic [3:0]                 pixel_color;
    logic                       pixel_on;
    logic [NUM_SPRITES*8-1:0]   sprite_ptr;

    logic [115:0] golden_mem [NUM_LINES];

    // dot clocks since the end of reset
    int dot_clocks;

    vic_fetch_top i_dut (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .den         (den),
        .yscroll     (yscroll),
        .bg_color    (bg_color),
        .sprite_dma  (sprite_dma),
        .dbi         (dbi),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .pixel_color (pixel_color),
        .pixel_on    (pixel_on),
        .sprite_ptr  (sprite_ptr)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #5 clk_dot4x = ~clk_dot4x;
    end

    initial begin : count_clocks
        dot_clocks = 0;
        forever begin
            @(posedge clk_dot4x);
            if (!rst)
                dot_clocks++;
        end
    end

    function automatic golden_rec_t record_of(input int line);
        if (line < 0 || line >= NUM_LINES)
            return '0;
        return golden_mem[6'(line)];
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // call on a falling edge
    task automatic wait_for_position(input int line, input int x);
        while (!(int'(raster_y) == line && int'(raster_x) == x)) begin
            @(negedge clk_dot4x);
        end
    endtask

    // the first pixel has to hold for its whole window and no longer
    task automatic check_first_pixel(input int line, input int col, input logic [7:0] expected);
        wait_for_position(line, FIRST_G_CYCLE + col);
        repeat (FIRST_PIXEL_CLOCK) @(negedge clk_dot4x);
        for (int i = 0; i < DOT4X_PER_PIXEL; i++) begin
            check_value(64'(pixel_color), 64'(expected[7:4]),
                        $sformatf("line %0d column %0d pixel_color", line, col));
            check_value(64'(pixel_on), 64'(expected[0]),
                        $sformatf("line %0d column %0d pixel_on", line, col));
            if (i < DOT4X_PER_PIXEL - 1)
                @(negedge clk_dot4x);
        end
    endtask

    // memory model and line stimulus, all taken from the current raster position
    initial begin : drive_inputs
        int          y;
        golden_rec_t cur_rec;
        golden_rec_t next_rec;
        logic        line_bad;
        logic [11:0] next_dbi;
        den = 1'b0;
        yscroll = 3'd0;
        bg_color = BG_COLOR;
        sprite_dma = '0;
        dbi = '0;
        forever begin
            @(negedge clk_dot4x);
            y = int'(raster_y);
            cur_rec = record_of(y);
            next_rec = record_of(y + 1);
            line_bad = cur_rec.den[0] && (y >= FIRST_DMA_LINE) && (y <= LAST_DMA_LINE)
                && (cur_rec.yscroll[2:0] == raster_y[2:0]);
            next_dbi = cur_rec.base + 12'(raster_x);
            // bad line bytes get bit 0 set so every character has a lit pixel
            if (line_bad)
                next_dbi[0] = 1'b1;
            dbi = next_dbi;
            sprite_dma = cur_rec.sprite_dma;
            // den and yscroll are sampled when the next line starts
            den = next_rec.den[0];
            yscroll = next_rec.yscroll[2:0];
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_dot4x);
            cycle_count++;
        end
        $display("Timeout: the raster did not reach the last line within %0d clock cycles",
                 TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    initial begin : run_lines
        golden_rec_t rec;
        rst = 1'b1;
        $readmemh(GOLDEN_FILE, golden_mem);
        repeat (2) @(negedge clk_dot4x);
        rst = 1'b0;
        for (int line = 0; line < NUM_LINES; line++) begin
            rec = record_of(line);
            wait_for_position(line, 0);
            // every line is CYCLES_PER_LINE phi cycles long, counted from the end of reset
            check_value(64'(dot_clocks), 64'(line * CYCLES_PER_LINE * DOT4X_PER_PHI),
                        $sformatf("line %0d start clock", line));
            check_first_pixel(line, 0, rec.col0);
            check_first_pixel(line, 3, rec.col3);
            check_first_pixel(line, NUM_COLUMNS - 1, rec.col39);
            // all p-accesses are done long before the last cycle
            wait_for_position(line, CYCLES_PER_LINE - 1);
            check_value(sprite_ptr, rec.sprite_ptr,
                        $sformatf("line %0d sprite_ptr", line));
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule : tb_vic_fetch

// File: hdl/vic_fetch_top.sv
`timescale 1ns/100ps

module vic_fetch_top (
    input  logic                                  clk_dot4x,
    input  logic                                  rst,
    input  logic                                  den,
    input  logic [2:0]                            yscroll,
    input  logic [3:0]                            bg_color,
    input  logic [vic_bus_pkg::NUM_SPRITES-1:0]   sprite_dma,
    input  logic [11:0]                           dbi,
    output logic [5:0]                            raster_x,
    output logic [8:0]                            raster_y,
    output logic [3:0]                            pixel_color,
    output logic                                  pixel_on,
    output logic [vic_bus_pkg::NUM_SPRITES*8-1:0] sprite_ptr
);
    import vic_bus_pkg::*;

    logic        phi_phase_start_dav;
    cycle_type_e cycle_type;
    logic        aec;
    logic        idle;
    logic [2:0]  sprite_cnt;
    logic [7:0]  pixels_read;
    logic [11:0] char_read;

    // raster position to bus cycle type
    cycle_sequencer i_cycle_sequencer (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .den                 (den),
        .yscroll             (yscroll),
        .raster_x            (raster_x),
        .raster_y            (raster_y),
        .phi_phase_start_dav (phi_phase_start_dav),
        .cycle_type          (cycle_type),
        .aec                 (aec),
        .idle                (idle),
        .sprite_cnt          (sprite_cnt)
    );

    bus_access i_bus_access (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .phi_phase_start_dav (phi_phase_start_dav),
        .cycle_type          (cycle_type),
        .dbi                 (dbi),
        .idle                (idle),
        .sprite_cnt          (sprite_cnt),
        .aec                 (aec),
        .sprite_dma          (sprite_dma),
        .sprite_ptr          (sprite_ptr),
        .pixels_read         (pixels_read),
        .char_read           (char_read)
    );

    // text mode serializer
    pixel_sequencer i_pixel_sequencer (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .phi_phase_start_dav (phi_phase_start_dav),
        .cycle_type          (cycle_type),
        .pixels_read         (pixels_read),
        .char_read           (char_read),
        .bg_color            (bg_color),
        .pixel_color         (pixel_color),
        .pixel_on            (pixel_on)
    );

endmodule : vic_fetch_top

// File: hdl/pixel_sequencer.sv
`timescale 1ns/100ps

module pixel_sequencer (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     phi_phase_start_dav,
    input  vic_bus_pkg::cycle_type_e cycle_type,
    input  logic [7:0]               pixels_read,
    input  logic [11:0]              char_read,
    input  logic [3:0]               bg_color,
    output logic [3:0]               pixel_color,
    output logic                     pixel_on
);
    import vic_bus_pkg::*;
    import vic_timing_pkg::*;

    logic       g_strobe_d;
    logic [7:0] shift_reg;
    logic [3:0] fg_color;
    logic [1:0] pix_cnt;
    logic [2:0] bit_cnt;
    logic       active;

    // bus_access has the byte one clock after the g-access strobe
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            g_strobe_d <= 1'b0;
        else
            g_strobe_d <= phi_phase_start_dav && (cycle_type == VIC_LG);
    end

    always_ff @(posedge clk_dot4x) begin
        if (g_strobe_d) begin
            shift_reg <= pixels_read;
            fg_color <= char_read[11:8];
        end else if (active && pix_cnt == 2'(DOT4X_PER_PIXEL - 1)) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    // window of 8 pixels, each held for DOT4X_PER_PIXEL clocks
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            active <= 1'b0;
            pix_cnt <= '0;
            bit_cnt <= '0;
        end else if (g_strobe_d) begin
            active <= 1'b1;
            pix_cnt <= '0;
            bit_cnt <= '0;
        end else if (active) begin
            pix_cnt <= pix_cnt + 2'd1;
            if (pix_cnt == 2'(DOT4X_PER_PIXEL - 1)) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                    active <= 1'b0;
            end
        end
    end

    // registered output, msb of the byte first
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color <= '0;
            pixel_on <= 1'b0;
        end else if (active && shift_reg[7]) begin
            pixel_color <= fg_color;
            pixel_on <= 1'b1;
        end else begin
            pixel_color <= bg_color;
            pixel_on <= 1'b0;
        end
    end

endmodule : pixel_sequencer

// File: hdl/bus_access.sv
`timescale 1ns/100ps

module bus_access (
    input  logic                                  clk_dot4x,
    input  logic                                  rst,
    input  logic                                  phi_phase_start_dav,
    input  vic_bus_pkg::cycle_type_e              cycle_type,
    input  logic [11:0]                           dbi,
    input  logic                                  idle,
    input  logic [2:0]                            sprite_cnt,
    input  logic                                  aec,
    input  logic [vic_bus_pkg::NUM_SPRITES-1:0]   sprite_dma,
    output logic [vic_bus_pkg::NUM_SPRITES*8-1:0] sprite_ptr,
    output logic [7:0]                            pixels_read,
    output logic [11:0]                           char_read
);
    import vic_bus_pkg::*;

    // colour nibble and pointer of each column, kept for the replay lines
    logic [11:0] char_buf [NUM_COLUMNS];
    logic [5:0]  char_buf_cnt;
    logic [11:0] char_next;
    logic [11:0] c_word;
    logic        c_access;
    logic        replay;
    logic [7:0]  sprite_ptr_q [NUM_SPRITES];

    assign c_access = phi_phase_start_dav && (cycle_type == VIC_HRC || cycle_type == VIC_HGC);
    assign replay = phi_phase_start_dav && (cycle_type == VIC_HRX || cycle_type == VIC_HGI);

    // colour is always read, the pointer only once the bus is ours
    assign c_word = {dbi[11:8], aec ? 8'hff : dbi[7:0]};

    always_ff @(posedge clk_dot4x) begin
        if (c_access) begin
            char_buf[char_buf_cnt] <= c_word;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (c_access)
            char_next <= c_word;
        else if (replay)
            char_next <= char_buf[char_buf_cnt];
    end

    // one step per c-access or replay, 40 per line
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            char_buf_cnt <= '0;
        end else if (c_access || replay) begin
            if (char_buf_cnt == 6'(NUM_COLUMNS - 1))
                char_buf_cnt <= '0;
            else
                char_buf_cnt <= char_buf_cnt + 6'd1;
        end
    end

    // g-access: bitmap byte plus the character fetched in the half cycle before
    always_ff @(posedge clk_dot4x) begin
        if (!aec && phi_phase_start_dav && cycle_type == VIC_LG) begin
            pixels_read <= dbi[7:0];
            char_read <= idle ? 12'd0 : char_next;
        end
    end

    // p-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                sprite_ptr_q[i] <= IDLE_SPRITE_PTR;
            end
        end else if (!aec && phi_phase_start_dav && cycle_type == VIC_LP) begin
            if (sprite_dma[sprite_cnt])
                sprite_ptr_q[sprite_cnt] <= dbi[7:0];
            else
                sprite_ptr_q[sprite_cnt] <= IDLE_SPRITE_PTR;
        end
    end

    // sprite 0 goes in the top byte
    always_comb begin
        for (int i = 0; i < NUM_SPRITES; i++) begin
            sprite_ptr[(NUM_SPRITES - 1 - i) * 8 +: 8] = sprite_ptr_q[i];
        end
    end

endmodule : bus_access

// File: hdl/cycle_sequencer.sv
`timescale 1ns/100ps

module cycle_sequencer (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     den,
    input  logic [2:0]               yscroll,
    output logic [5:0]               raster_x,
    output logic [8:0]               raster_y,
    output logic                     phi_phase_start_dav,
    output vic_bus_pkg::cycle_type_e cycle_type,
    output logic                     aec,
    output logic                     idle,
    output logic [2:0]               sprite_cnt
);
    import vic_bus_pkg::*;
    import vic_timing_pkg::*;

    logic [4:0] dot_cnt;
    logic [5:0] next_x;
    logic [8:0] next_y;
    logic       phi_end;
    logic       last_cycle;
    logic       bad_line;
    logic       next_bad;

    // even cycles from the first sprite slot carry one p-access each
    function automatic logic sprite_slot(input logic [5:0] x);
        int rel;
        rel = int'(x) - FIRST_SPRITE_CYCLE;
        return (rel >= 0) && (rel < 2 * NUM_SPRITES) && (rel % 2 == 0);
    endfunction

    function automatic logic [2:0] sprite_index(input logic [5:0] x);
        return 3'((int'(x) - FIRST_SPRITE_CYCLE) / 2);
    endfunction

    // sprite slots 6 and 7 overlap the refresh window and win over it
    function automatic cycle_type_e low_phase_type(input logic [5:0] x);
        int c;
        c = int'(x);
        if (sprite_slot(x))
            return VIC_LP;
        else if (c >= REFRESH_FIRST_CYCLE && c <= FIRST_C_CYCLE)
            return VIC_LR;
        else if (c >= FIRST_G_CYCLE && c < FIRST_G_CYCLE + NUM_COLUMNS)
            return VIC_LG;
        else
            return VIC_LI;
    endfunction

    function automatic cycle_type_e high_phase_type(input logic [5:0] x, input logic bad);
        int c;
        c = int'(x);
        if (sprite_slot(x))
            return VIC_HS;
        else if (c == FIRST_C_CYCLE)
            return bad ? VIC_HRC : VIC_HRX;
        else if (c >= FIRST_G_CYCLE && c < FIRST_C_CYCLE + NUM_COLUMNS)
            return bad ? VIC_HGC : VIC_HGI;
        else
            return VIC_HI;
    endfunction

    // high phases where the chip already owns the bus
    function automatic logic bus_owned(input logic [5:0] x, input logic bad);
        int c;
        c = int'(x);
        return bad && (c >= FIRST_C_CYCLE + BUS_GRAB_CYCLES)
            && (c < FIRST_C_CYCLE + NUM_COLUMNS);
    endfunction

    function automatic logic is_bad_line(
        input logic [8:0] y,
        input logic       den_i,
        input logic [2:0] ys
    );
        return den_i && (int'(y) >= FIRST_DMA_LINE) && (int'(y) <= LAST_DMA_LINE)
            && (y[2:0] == ys);
    endfunction

    assign phi_end = (dot_cnt == 5'(DOT4X_PER_PHI - 1));
    assign last_cycle = (raster_x == 6'(CYCLES_PER_LINE - 1));
    assign next_x = last_cycle ? 6'd0 : raster_x + 6'd1;
    assign next_y = (raster_y == 9'(LINES_PER_FRAME - 1)) ? 9'd0 : raster_y + 9'd1;

    // bad line condition of the line that is about to start
    assign next_bad = is_bad_line(next_y, den, yscroll);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_cnt <= '0;
            raster_x <= '0;
            raster_y <= '0;
            bad_line <= 1'b0;
            idle <= 1'b1;
            aec <= 1'b0;
            phi_phase_start_dav <= 1'b0;
            cycle_type <= VIC_LI;
            sprite_cnt <= '0;
        end else begin
            phi_phase_start_dav <= 1'b0;
            if (phi_end) begin
                // low phase of the next phi cycle starts
                dot_cnt <= '0;
                raster_x <= next_x;
                phi_phase_start_dav <= 1'b1;
                cycle_type <= low_phase_type(next_x);
                aec <= 1'b0;
                if (sprite_slot(next_x)) begin
                    sprite_cnt <= sprite_index(next_x);
                end
                if (last_cycle) begin
                    raster_y <= next_y;
                    bad_line <= next_bad;
                    if (int'(next_y) == LAST_DMA_LINE + 1)
                        idle <= 1'b1;
                    else if (next_bad)
                        idle <= 1'b0;
                end
            end else begin
                dot_cnt <= dot_cnt + 5'd1;
                if (dot_cnt == 5'(DOT4X_PER_HALF - 1)) begin
                    // high phase of the current phi cycle starts
                    phi_phase_start_dav <= 1'b1;
                    cycle_type <= high_phase_type(raster_x, bad_line);
                    aec <= !bus_owned(raster_x, bad_line);
                end
            end
        end
    end

endmodule : cycle_sequencer

// File: hdl/vic_timing_pkg.sv
package vic_timing_pkg;

    // dot4x clocks per phi cycle and per half phi cycle
    localparam int DOT4X_PER_PHI = 32;
    localparam int DOT4X_PER_HALF = 16;

    // one output pixel lasts this many dot4x clocks
    localparam int DOT4X_PER_PIXEL = 4;

    // raster geometry
    localparam int CYCLES_PER_LINE = 63;
    localparam int LINES_PER_FRAME = 312;

    // window of lines that may become bad lines
    localparam int FIRST_DMA_LINE = 48;
    localparam int LAST_DMA_LINE = 247;

    // phi cycle positions within a line
    localparam int FIRST_SPRITE_CYCLE = 0;
    localparam int REFRESH_FIRST_CYCLE = 11;
    localparam int FIRST_C_CYCLE = 15;
    localparam int FIRST_G_CYCLE = 16;

    // c-accesses at the start of a bad line before the CPU releases the bus
    localparam int BUS_GRAB_CYCLES = 3;

endpackage : vic_timing_pkg

// File: hdl/vic_bus_pkg.sv
package vic_bus_pkg;

    // bus cycle type of one half phi cycle
    // low phase types start with VIC_L, high phase types with VIC_H
    typedef enum logic [3:0] {
        // sprite pointer fetch
        VIC_LP  = 4'd0,
        // sprite data, low half (not serviced here)
        VIC_LS  = 4'd1,
        // dram refresh
        VIC_LR  = 4'd2,
        // bitmap fetch
        VIC_LG  = 4'd3,
        // idle low phase
        VIC_LI  = 4'd4,
        // sprite data, high half (not serviced here)
        VIC_HS  = 4'd5,
        // bad line c-access following a refresh cycle
        VIC_HRC = 4'd6,
        // bad line c-access following a g-access
        VIC_HGC = 4'd7,
        // replay from line buffer following a refresh cycle
        VIC_HRX = 4'd8,
        // replay from line buffer following a g-access
        VIC_HGI = 4'd9,
        // idle high phase
        VIC_HI  = 4'd10
    } cycle_type_e;

    // hardware sprites, each with one pointer fetch per line
    localparam int NUM_SPRITES = 8;

    // character columns fetched on a bad line
    localparam int NUM_COLUMNS = 40;

    // pointer seen by the sprite logic while its DMA is off
    localparam logic [7:0] IDLE_SPRITE_PTR = 8'hff;

endpackage : vic_bus_pkg
